// File: common/iq_pkg.sv
`default_nettype none

package iq_pkg;

    // ------------------------------------------------------------
    // queue geometry
    // ------------------------------------------------------------

    // number of issue queue slots
    localparam int IQ_DEPTH = 4;

    // slot index width, used for the issue pointer
    localparam int IDX_W = $clog2(IQ_DEPTH);

    // source operands per instruction
    localparam int REG_COUNT = 2;

    // ------------------------------------------------------------
    // forwarding lanes
    // ------------------------------------------------------------

    // result bus lanes
    localparam int CDB_COUNT = 2;

    // speculative wakeup lanes
    localparam int WKUP_COUNT = 2;

    // cycles from wakeup tag to wakeup data, fixed by two stages in the entry
    localparam int WKUP_DELAY = 2;

    // ------------------------------------------------------------
    // payload widths
    // ------------------------------------------------------------

    // operand data
    localparam int WORD_W = 32;

    // producer tag, a reorder buffer index
    localparam int TAG_W = 5;

    // decode info carried with the instruction
    localparam int DI_W = 16;

endpackage

`default_nettype wire

// File: common/iq_fwd_if.sv
`timescale 1ns/100ps
`default_nettype none

interface iq_fwd_if;

    // wakeup lanes, data trails the tag by two cycles
    logic [iq_pkg::WKUP_COUNT-1:0][iq_pkg::TAG_W-1:0]  wkup_tag;
    logic [iq_pkg::WKUP_COUNT-1:0][iq_pkg::WORD_W-1:0] wkup_data;
    logic [iq_pkg::WKUP_COUNT-1:0]                     wkup_valid;

    // result bus lanes, tag and data in the same cycle
    logic [iq_pkg::CDB_COUNT-1:0][iq_pkg::TAG_W-1:0]   cdb_tag;
    logic [iq_pkg::CDB_COUNT-1:0][iq_pkg::WORD_W-1:0]  cdb_data;
    logic [iq_pkg::CDB_COUNT-1:0]                      cdb_valid;

    // driver side
    modport src (
        output wkup_tag, wkup_data, wkup_valid,
        output cdb_tag, cdb_data, cdb_valid
    );

    // every queue slot listens
    modport ent (
        input wkup_tag, wkup_data, wkup_valid,
        input cdb_tag, cdb_data, cdb_valid
    );

endinterface

`default_nettype wire

// File: issue_queue/iq_entry.sv
`timescale 1ns/100ps
`default_nettype none

module iq_entry (
    input  logic                                            clk,
    input  logic                                            rst_n_i,
    input  logic                                            flush_i,
    input  logic                                            init_i,
    input  logic                                            select_i,

    input  logic [iq_pkg::REG_COUNT-1:0][iq_pkg::WORD_W-1:0] data_i,
    input  logic [iq_pkg::REG_COUNT-1:0][iq_pkg::TAG_W-1:0]  tag_i,
    input  logic [iq_pkg::REG_COUNT-1:0]                     data_valid_i,
    input  logic [iq_pkg::DI_W-1:0]                          di_i,

    iq_fwd_if.ent                                            fwd,

    output logic                                            valid_o,
    output logic                                            ready_o,
    output logic [iq_pkg::REG_COUNT-1:0][iq_pkg::WORD_W-1:0] data_o,
    output logic [iq_pkg::DI_W-1:0]                          di_o
);

    // ------------------------------------------------------------
    // slot state
    // ------------------------------------------------------------

    logic                                             entry_valid;
    logic [iq_pkg::REG_COUNT-1:0]                     ready_q;
    logic [iq_pkg::REG_COUNT-1:0][iq_pkg::WORD_W-1:0] data_q;
    logic [iq_pkg::REG_COUNT-1:0][iq_pkg::TAG_W-1:0]  tag_q;
    logic [iq_pkg::DI_W-1:0]                          di_q;

    // per operand, per lane match vectors
    logic [iq_pkg::REG_COUNT-1:0][iq_pkg::CDB_COUNT-1:0]  cdb_hit;
    logic [iq_pkg::REG_COUNT-1:0][iq_pkg::WKUP_COUNT-1:0] wkup_hit;
    logic [iq_pkg::REG_COUNT-1:0][iq_pkg::WKUP_COUNT-1:0] wkup_hit_q;
    logic [iq_pkg::REG_COUNT-1:0][iq_pkg::WKUP_COUNT-1:0] wkup_hit_qq;

    logic [iq_pkg::REG_COUNT-1:0][iq_pkg::WORD_W-1:0] cdb_result;
    logic [iq_pkg::REG_COUNT-1:0][iq_pkg::WORD_W-1:0] wkup_result;

    // wakeup in flight, and wakeup data arriving this cycle
    logic [iq_pkg::REG_COUNT-1:0]                     pending;
    logic [iq_pkg::REG_COUNT-1:0]                     arrive;

    // ------------------------------------------------------------
    // tag match
    // ------------------------------------------------------------

    always_comb begin
        cdb_hit     = '0;
        cdb_result  = '0;
        wkup_hit    = '0;
        wkup_result = '0;
        for (int i = 0; i < iq_pkg::REG_COUNT; i++) begin
            pending[i] = (|wkup_hit_q[i]) | (|wkup_hit_qq[i]);
            arrive[i]  = |wkup_hit_qq[i];

            // result bus, own lane valid only
            for (int j = 0; j < iq_pkg::CDB_COUNT; j++) begin
                cdb_hit[i][j] = entry_valid & ~ready_q[i] & ~pending[i] &
                                fwd.cdb_valid[j] & (fwd.cdb_tag[j] == tag_q[i]);
                cdb_result[i] = cdb_result[i] |
                                (cdb_hit[i][j] ? fwd.cdb_data[j] : '0);
            end

            // a same-cycle result bus hit wins over a wakeup
            for (int j = 0; j < iq_pkg::WKUP_COUNT; j++) begin
                wkup_hit[i][j] = entry_valid & ~ready_q[i] & ~pending[i] &
                                 ~(|cdb_hit[i]) & fwd.wkup_valid[j] &
                                 (fwd.wkup_tag[j] == tag_q[i]);
                wkup_result[i] = wkup_result[i] |
                                 (wkup_hit_qq[i][j] ? fwd.wkup_data[j] : '0);
            end
        end
    end

    // ------------------------------------------------------------
    // control state
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            entry_valid <= 1'b0;
        end else if (init_i) begin
            entry_valid <= 1'b1;
        end else if (select_i) begin
            entry_valid <= 1'b0;
        end
    end

    // operand ready on dispatch, on a result bus hit, or on wakeup data
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            ready_q <= '0;
        end else if (init_i) begin
            ready_q <= data_valid_i;
        end else begin
            for (int i = 0; i < iq_pkg::REG_COUNT; i++) begin
                if ((|cdb_hit[i]) || arrive[i]) begin
                    ready_q[i] <= 1'b1;
                end
            end
        end
    end

    // two stage wakeup pipe, cancelled when the slot leaves
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i || init_i || select_i) begin
            wkup_hit_q  <= '0;
            wkup_hit_qq <= '0;
        end else begin
            wkup_hit_q  <= wkup_hit;
            wkup_hit_qq <= wkup_hit_q;
        end
    end

    // ------------------------------------------------------------
    // payload
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (init_i) begin
            data_q <= data_i;
            tag_q  <= tag_i;
            di_q   <= di_i;
        end else begin
            for (int i = 0; i < iq_pkg::REG_COUNT; i++) begin
                if (|cdb_hit[i]) begin
                    data_q[i] <= cdb_result[i];
                end else if (arrive[i]) begin
                    data_q[i] <= wkup_result[i];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------

    assign valid_o = entry_valid;

    // wakeup data counts as ready in its arrival cycle
    assign ready_o = entry_valid & (&(ready_q | arrive));

    always_comb begin
        for (int i = 0; i < iq_pkg::REG_COUNT; i++) begin
            data_o[i] = arrive[i] ? wkup_result[i] : data_q[i];
        end
    end

    assign di_o = di_q;

endmodule

`default_nettype wire

// File: issue_queue/iq_sched.sv
`timescale 1ns/100ps
`default_nettype none

module iq_sched (
    input  logic [iq_pkg::IQ_DEPTH-1:0] valid_i,
    input  logic [iq_pkg::IQ_DEPTH-1:0] ready_i,
    input  logic                        dispatch_valid_i,

    output logic [iq_pkg::IQ_DEPTH-1:0] init_o,
    output logic [iq_pkg::IQ_DEPTH-1:0] select_o,
    output logic                        dispatch_ready_o,
    output logic                        issue_valid_o,
    output logic [iq_pkg::IDX_W-1:0]    issue_idx_o
);

    logic found_free;
    logic found_ready;

    // ------------------------------------------------------------
    // dispatch side, lowest free slot
    // ------------------------------------------------------------

    always_comb begin
        init_o     = '0;
        found_free = 1'b0;
        for (int i = 0; i < iq_pkg::IQ_DEPTH; i++) begin
            if (!valid_i[i] && !found_free) begin
                found_free = 1'b1;
                init_o[i]  = dispatch_valid_i;
            end
        end
    end

    assign dispatch_ready_o = found_free;

    // ------------------------------------------------------------
    // issue side, lowest ready slot
    // ------------------------------------------------------------

    always_comb begin
        select_o    = '0;
        issue_idx_o = '0;
        found_ready = 1'b0;
        for (int i = 0; i < iq_pkg::IQ_DEPTH; i++) begin
            if (ready_i[i] && !found_ready) begin
                found_ready = 1'b1;
                select_o[i] = 1'b1;
                issue_idx_o = i[iq_pkg::IDX_W-1:0];
            end
        end
    end

    assign issue_valid_o = found_ready;

endmodule

`default_nettype wire

// File: issue_queue/issue_queue.sv
`timescale 1ns/100ps
`default_nettype none

module issue_queue (
    input  logic                                              clk,
    input  logic                                              rst_n_i,
    input  logic                                              flush_i,

    // dispatch
    input  logic                                              dispatch_valid_i,
    input  logic [iq_pkg::REG_COUNT-1:0][iq_pkg::WORD_W-1:0]  dispatch_data_i,
    input  logic [iq_pkg::REG_COUNT-1:0][iq_pkg::TAG_W-1:0]   dispatch_tag_i,
    input  logic [iq_pkg::REG_COUNT-1:0]                      dispatch_data_valid_i,
    input  logic [iq_pkg::DI_W-1:0]                           dispatch_di_i,

    // speculative wakeup
    input  logic [iq_pkg::WKUP_COUNT-1:0][iq_pkg::TAG_W-1:0]  wkup_tag_i,
    input  logic [iq_pkg::WKUP_COUNT-1:0][iq_pkg::WORD_W-1:0] wkup_data_i,
    input  logic [iq_pkg::WKUP_COUNT-1:0]                     wkup_valid_i,

    // result bus
    input  logic [iq_pkg::CDB_COUNT-1:0][iq_pkg::TAG_W-1:0]   cdb_tag_i,
    input  logic [iq_pkg::CDB_COUNT-1:0][iq_pkg::WORD_W-1:0]  cdb_data_i,
    input  logic [iq_pkg::CDB_COUNT-1:0]                      cdb_valid_i,

    output logic                                              dispatch_ready_o,
    output logic                                              issue_valid_o,
    output logic [iq_pkg::REG_COUNT-1:0][iq_pkg::WORD_W-1:0]  issue_data_o,
    output logic [iq_pkg::DI_W-1:0]                           issue_di_o
);

    // ------------------------------------------------------------
    // broadcast lanes
    // ------------------------------------------------------------

    iq_fwd_if fwd ();

    assign fwd.wkup_tag   = wkup_tag_i;
    assign fwd.wkup_data  = wkup_data_i;
    assign fwd.wkup_valid = wkup_valid_i;
    assign fwd.cdb_tag    = cdb_tag_i;
    assign fwd.cdb_data   = cdb_data_i;
    assign fwd.cdb_valid  = cdb_valid_i;

    // ------------------------------------------------------------
    // scheduler
    // ------------------------------------------------------------

    logic [iq_pkg::IQ_DEPTH-1:0] ent_valid;
    logic [iq_pkg::IQ_DEPTH-1:0] ent_ready;
    logic [iq_pkg::IQ_DEPTH-1:0] ent_init;
    logic [iq_pkg::IQ_DEPTH-1:0] ent_select;
    logic [iq_pkg::IDX_W-1:0]    issue_idx;

    iq_sched u_sched (
        .valid_i          (ent_valid),
        .ready_i          (ent_ready),
        .dispatch_valid_i (dispatch_valid_i),
        .init_o           (ent_init),
        .select_o         (ent_select),
        .dispatch_ready_o (dispatch_ready_o),
        .issue_valid_o    (issue_valid_o),
        .issue_idx_o      (issue_idx)
    );

    // ------------------------------------------------------------
    // queue slots
    // ------------------------------------------------------------

    logic [iq_pkg::IQ_DEPTH-1:0][iq_pkg::REG_COUNT-1:0][iq_pkg::WORD_W-1:0] ent_data;
    logic [iq_pkg::IQ_DEPTH-1:0][iq_pkg::DI_W-1:0]                          ent_di;

    for (genvar s = 0; s < iq_pkg::IQ_DEPTH; s++) begin : g_slot
        iq_entry u_entry (
            .clk          (clk),
            .rst_n_i      (rst_n_i),
            .flush_i      (flush_i),
            .init_i       (ent_init[s]),
            .select_i     (ent_select[s]),
            .data_i       (dispatch_data_i),
            .tag_i        (dispatch_tag_i),
            .data_valid_i (dispatch_data_valid_i),
            .di_i         (dispatch_di_i),
            .fwd          (fwd.ent),
            .valid_o      (ent_valid[s]),
            .ready_o      (ent_ready[s]),
            .data_o       (ent_data[s]),
            .di_o         (ent_di[s])
        );
    end

    // issued slot onto the execution side
    assign issue_data_o = ent_data[issue_idx];
    assign issue_di_o   = ent_di[issue_idx];

endmodule

`default_nettype wire

// File: verification/iq_ref.svh
`ifndef IQ_REF_SVH
`define IQ_REF_SVH

// ------------------------------------------------------------
// slot model, indexed by slot then operand
// ------------------------------------------------------------

logic                                             slot_valid [0:iq_pkg::IQ_DEPTH-1];
logic [iq_pkg::REG_COUNT-1:0]                     slot_rdy   [0:iq_pkg::IQ_DEPTH-1];
logic [iq_pkg::REG_COUNT-1:0][iq_pkg::WORD_W-1:0] slot_data  [0:iq_pkg::IQ_DEPTH-1];
logic [iq_pkg::REG_COUNT-1:0][iq_pkg::TAG_W-1:0]  slot_tag   [0:iq_pkg::IQ_DEPTH-1];
logic [iq_pkg::DI_W-1:0]                          slot_di    [0:iq_pkg::IQ_DEPTH-1];
// wakeup countdown, 1 in the cycle its data shows up on slot_lane
int slot_cnt  [0:iq_pkg::IQ_DEPTH-1][0:iq_pkg::REG_COUNT-1];
int slot_lane [0:iq_pkg::IQ_DEPTH-1][0:iq_pkg::REG_COUNT-1];

// expected outputs of this cycle, plus issued slot and lowest free slot
function automatic void predict(output logic iv,
        output logic [iq_pkg::REG_COUNT-1:0][iq_pkg::WORD_W-1:0] idata,
        output logic [iq_pkg::DI_W-1:0] idi, output logic dr,
        output int issued, output int free);
    logic op_ok;
    issued = -1;
    free   = -1;
    for (int s = iq_pkg::IQ_DEPTH - 1; s >= 0; s--) begin
        op_ok = slot_valid[s];
        for (int r = 0; r < iq_pkg::REG_COUNT; r++) begin
            op_ok = op_ok & (slot_rdy[s][r] | (slot_cnt[s][r] == 1));
        end
        if (slot_valid[s] === 1'b0) free = s;
        if (op_ok === 1'b1) issued = s;
    end
    iv    = (issued >= 0);
    dr    = (free >= 0);
    idata = '0;
    idi   = '0;
    if (iv) begin
        idi = slot_di[issued];
        for (int r = 0; r < iq_pkg::REG_COUNT; r++) begin
            idata[r] = (slot_cnt[issued][r] == 1) ? wkup_data_i[slot_lane[issued][r]]
                                                  : slot_data[issued][r];
        end
    end
endfunction

// model state after the coming clock edge
function automatic void advance(input int issued, input int free);
    int hit;
    for (int s = 0; s < iq_pkg::IQ_DEPTH; s++) begin
        for (int r = 0; r < iq_pkg::REG_COUNT; r++) begin
            hit = -1;
            if (slot_cnt[s][r] == 1) begin
                slot_data[s][r] = wkup_data_i[slot_lane[s][r]];
                slot_rdy[s][r]  = 1'b1;
            end else if (slot_cnt[s][r] == 0 && slot_valid[s] === 1'b1 &&
                         !slot_rdy[s][r]) begin
                for (int j = iq_pkg::CDB_COUNT - 1; j >= 0; j--) begin
                    if (cdb_valid_i[j] && cdb_tag_i[j] == slot_tag[s][r]) hit = j;
                end
                if (hit >= 0) begin
                    slot_data[s][r] = cdb_data_i[hit];
                    slot_rdy[s][r]  = 1'b1;
                end else begin
                    for (int j = iq_pkg::WKUP_COUNT - 1; j >= 0; j--) begin
                        if (wkup_valid_i[j] && wkup_tag_i[j] == slot_tag[s][r]) hit = j;
                    end
                    slot_lane[s][r] = hit;
                    if (hit >= 0) slot_cnt[s][r] = iq_pkg::WKUP_DELAY + 1;
                end
            end
            if (slot_cnt[s][r] > 0) slot_cnt[s][r] = slot_cnt[s][r] - 1;
            if (!rst_n_i || flush_i || s == issued) slot_cnt[s][r] = 0;
        end
        if (!rst_n_i || flush_i || s == issued) begin
            slot_valid[s] = 1'b0;
        end else if (dispatch_valid_i && s == free) begin
            slot_valid[s] = 1'b1;
            slot_data[s]  = dispatch_data_i;
            slot_tag[s]   = dispatch_tag_i;
            slot_rdy[s]   = dispatch_data_valid_i;
            slot_di[s]    = dispatch_di_i;
        end
    end
endfunction

`endif

// File: verification/tb_issue_queue.sv
`timescale 1ns/100ps
`default_nettype none

module tb_issue_queue;

    logic                                              clk;
    logic                                              rst_n_i;
    logic                                              flush_i;
    logic                                              dispatch_valid_i;
    logic [iq_pkg::REG_COUNT-1:0][iq_pkg::WORD_W-1:0]  dispatch_data_i;
    logic [iq_pkg::REG_COUNT-1:0][iq_pkg::TAG_W-1:0]   dispatch_tag_i;
    logic [iq_pkg::REG_COUNT-1:0]                      dispatch_data_valid_i;
    logic [iq_pkg::DI_W-1:0]                           dispatch_di_i;
    logic [iq_pkg::WKUP_COUNT-1:0][iq_pkg::TAG_W-1:0]  wkup_tag_i;
    logic [iq_pkg::WKUP_COUNT-1:0][iq_pkg::WORD_W-1:0] wkup_data_i;
    logic [iq_pkg::WKUP_COUNT-1:0]                     wkup_valid_i;
    logic [iq_pkg::CDB_COUNT-1:0][iq_pkg::TAG_W-1:0]   cdb_tag_i;
    logic [iq_pkg::CDB_COUNT-1:0][iq_pkg::WORD_W-1:0]  cdb_data_i;
    logic [iq_pkg::CDB_COUNT-1:0]                      cdb_valid_i;
    logic                                              dispatch_ready_o;
    logic                                              issue_valid_o;
    logic [iq_pkg::REG_COUNT-1:0][iq_pkg::WORD_W-1:0]  issue_data_o;
    logic [iq_pkg::DI_W-1:0]                           issue_di_o;

    // model outputs for the current cycle
    logic                                              exp_valid;
    logic                                              exp_ready;
    logic [iq_pkg::REG_COUNT-1:0][iq_pkg::WORD_W-1:0]  exp_data;
    logic [iq_pkg::DI_W-1:0]                           exp_di;
    int                                                exp_slot;
    int                                                free_slot;
    logic                                              hold;

    `include "iq_ref.svh"

    issue_queue dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_issue_valid(input logic exp);
        if (issue_valid_o !== exp)
            stop_run($sformatf("Fail at %0t: issue_valid_o expected %b, got %b",
                               $time, exp, issue_valid_o));
    endtask

    task automatic check_dispatch_ready(input logic exp);
        if (dispatch_ready_o !== exp)
            stop_run($sformatf("Fail at %0t: dispatch_ready_o expected %b, got %b",
                               $time, exp, dispatch_ready_o));
    endtask

    task automatic check_word(input string name, input logic [iq_pkg::WORD_W-1:0] exp,
                              input logic [iq_pkg::WORD_W-1:0] act);
        if (act !== exp)
            stop_run($sformatf("Fail at %0t: %s expected %h, got %h", $time, name, exp, act));
    endtask

    task automatic check_di(input logic [iq_pkg::DI_W-1:0] exp,
                            input logic [iq_pkg::DI_W-1:0] act);
        if (act !== exp)
            stop_run($sformatf("Fail at %0t: issue_di_o expected %h, got %h", $time, exp, act));
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        predict(exp_valid, exp_data, exp_di, exp_ready, exp_slot, free_slot);
        if (rst_n_i) begin
            check_issue_valid(exp_valid);
            check_dispatch_ready(exp_ready);
            if (exp_valid) begin
                for (int r = 0; r < iq_pkg::REG_COUNT; r++) begin
                    check_word($sformatf("issue_data_o[%0d]", r), exp_data[r], issue_data_o[r]);
                end
                check_di(exp_di, issue_di_o);
            end
        end
        advance(exp_slot, free_slot);
    end

    // ------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------

    // strobes drop, lane data changes every cycle
    task automatic next_cycle();
        @(posedge clk);
        #1;
        dispatch_valid_i = 1'b0;
        flush_i          = 1'b0;
        cdb_valid_i      = '0;
        wkup_valid_i     = '0;
        cdb_data_i       = {$urandom, $urandom};
        wkup_data_i      = {$urandom, $urandom};
    endtask

    // two different tags out of a small pool so that matches happen
    function automatic logic [1:0][iq_pkg::TAG_W-1:0] distinct_tags();
        int a;
        int b;
        a = $urandom % 8;
        b = (a + 1 + $urandom % 7) % 8;
        return {b[iq_pkg::TAG_W-1:0], a[iq_pkg::TAG_W-1:0]};
    endfunction

    // held until dispatch_ready_o is seen
    task automatic dispatch_instr(input logic [iq_pkg::REG_COUNT-1:0] dv,
                                  input logic [iq_pkg::REG_COUNT-1:0][iq_pkg::TAG_W-1:0] tags);
        int n;
        dispatch_data_i       = {$urandom, $urandom};
        dispatch_tag_i        = tags;
        dispatch_data_valid_i = dv;
        dispatch_di_i         = 16'($urandom);
        for (n = 0; n < 20; n++) begin
            dispatch_valid_i = 1'b1;
            @(negedge clk);
            if (dispatch_ready_o) break;
            next_cycle();
        end
        if (n == 20) stop_run("dispatch was never accepted by the queue");
        next_cycle();
    endtask

    task automatic wait_issue_valid(input logic level, input int limit);
        int n;
        for (n = 0; n < limit; n++) begin
            @(negedge clk);
            if (issue_valid_o === level) break;
            next_cycle();
        end
        if (n == limit) stop_run("timed out waiting for issue_valid_o to change");
        next_cycle();
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------

    initial begin
        void'($urandom(32'hcc38_2f27));
        rst_n_i               = 1'b0;
        flush_i               = 1'b0;
        dispatch_valid_i      = 1'b0;
        dispatch_data_i       = '0;
        dispatch_tag_i        = '0;
        dispatch_data_valid_i = '0;
        dispatch_di_i         = '0;
        wkup_tag_i            = '0;
        wkup_data_i           = '0;
        wkup_valid_i          = '0;
        cdb_tag_i             = '0;
        cdb_data_i            = '0;
        cdb_valid_i           = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        // two waiting on tag 3, one ready at once
        dispatch_instr(2'b01, {5'd3, 5'd0});
        dispatch_instr(2'b10, {5'd0, 5'd3});
        dispatch_instr(2'b11, '0);
        // tag 3 on a lane whose valid is low
        cdb_valid_i = 2'b10;
        cdb_tag_i   = {5'd9, 5'd3};
        next_cycle();
        cdb_valid_i = 2'b10;
        cdb_tag_i   = {5'd3, 5'd9};
        next_cycle();
        wait_issue_valid(1'b0, 20);

        // speculative wakeup on lane 1
        dispatch_instr(2'b10, {5'd0, 5'd5});
        wkup_valid_i = 2'b10;
        wkup_tag_i   = {5'd5, 5'd6};
        next_cycle();
        wait_issue_valid(1'b1, 10);
        wait_issue_valid(1'b0, 10);

        // full queue holds the fifth request until a slot frees
        repeat (4) dispatch_instr(2'b10, {5'd0, 5'd7});
        cdb_valid_i = 2'b01;
        cdb_tag_i   = {5'd8, 5'd7};
        dispatch_instr(2'b11, '0);
        wait_issue_valid(1'b0, 20);

        // flush with one waiting and one ready
        dispatch_instr(2'b00, {5'd9, 5'd9});
        dispatch_instr(2'b11, '0);
        flush_i = 1'b1;
        next_cycle();
        // tag 9 would wake the waiting slot if it survived
        cdb_valid_i = 2'b01;
        cdb_tag_i   = {5'd0, 5'd9};
        next_cycle();
        next_cycle();
        dispatch_instr(2'b11, '0);
        wait_issue_valid(1'b0, 10);

        // random traffic where a refused request stays on the bus
        hold = 1'b0;
        for (int c = 0; c < 300; c++) begin
            if (!hold) begin
                dispatch_valid_i      = ($urandom % 3) != 0;
                dispatch_data_i       = {$urandom, $urandom};
                dispatch_tag_i        = distinct_tags();
                dispatch_data_valid_i = 2'($urandom);
                dispatch_di_i         = 16'($urandom);
            end
            cdb_valid_i  = 2'($urandom);
            cdb_tag_i    = distinct_tags();
            cdb_data_i   = {$urandom, $urandom};
            wkup_valid_i = 2'($urandom);
            wkup_tag_i   = distinct_tags();
            wkup_data_i  = {$urandom, $urandom};
            @(negedge clk);
            hold = dispatch_valid_i && !dispatch_ready_o;
            @(posedge clk);
            #1;
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verification
common/iq_pkg.sv
common/iq_fwd_if.sv
issue_queue/iq_entry.sv
issue_queue/iq_sched.sv
issue_queue/issue_queue.sv
verification/tb_issue_queue.sv
